/* all.f */
+incdir+hw
+incdir+sim
hw/fxp_pkg.sv
hw/fxp_addsub_cmp.sv
hw/fxp_mult_pipe.sv
hw/fxp_div_iter.sv
hw/fxp_sdiv.sv
hw/fxp_alu_top.sv
sim/fxp_alu_tb.sv

/* Makefile */
# Verilator build and run of the fixed-point unit testbench.
SIM       := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := fxp_alu_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := TESTS FAILED
PASS_MSG  := TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run $(TOP) and search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/fxp_model.svh */
// Reference results per opcode for Q16.16 words; include inside a module body that imports fxp_pkg.
`ifndef FXP_MODEL_SVH
`define FXP_MODEL_SVH

// Bits 47 down to 16 of the full 64-bit product.
function automatic fxp_word_t expected_product(fxp_word_t a, fxp_word_t b, logic sgn);
  logic [2*`FXP_WIDTH-1:0] wide_a;
  logic [2*`FXP_WIDTH-1:0] wide_b;
  logic [2*`FXP_WIDTH-1:0] full;
  wide_a = sgn ? {{`FXP_WIDTH{a[`FXP_WIDTH-1]}}, a} : {{`FXP_WIDTH{1'b0}}, a};
  wide_b = sgn ? {{`FXP_WIDTH{b[`FXP_WIDTH-1]}}, b} : {{`FXP_WIDTH{1'b0}}, b};
  full = wide_a * wide_b;
  return full[`FXP_WIDTH+`FXP_FRAC_WIDTH-1:`FXP_FRAC_WIDTH];
endfunction

// Magnitude division, then the sign is put back, so signed results truncate toward zero.
function automatic fxp_word_t expected_quotient(fxp_word_t a, fxp_word_t b, logic sgn);
  logic                    neg_a;
  logic                    neg_b;
  fxp_word_t               mag_a;
  fxp_word_t               mag_b;
  fxp_word_t               mag_q;
  logic [2*`FXP_WIDTH-1:0] numer;
  logic [2*`FXP_WIDTH-1:0] full_q;
  neg_a = sgn && a[`FXP_WIDTH-1];
  neg_b = sgn && b[`FXP_WIDTH-1];
  mag_a = neg_a ? (32'd0 - a) : a;
  mag_b = neg_b ? (32'd0 - b) : b;
  if (mag_b == 32'd0) begin
    mag_q = '1;  // Divide by zero saturates the magnitude.
  end else begin
    numer  = {32'd0, mag_a} << `FXP_FRAC_WIDTH;
    full_q = numer / {32'd0, mag_b};
    mag_q  = full_q[`FXP_WIDTH-1:0];
  end
  return (neg_a != neg_b) ? (32'd0 - mag_q) : mag_q;
endfunction

// Flipping the top bit turns a two's complement order into an unsigned one.
function automatic logic expected_less(fxp_word_t a, fxp_word_t b, logic sgn);
  fxp_word_t key_a;
  fxp_word_t key_b;
  key_a = sgn ? {~a[`FXP_WIDTH-1], a[`FXP_WIDTH-2:0]} : a;
  key_b = sgn ? {~b[`FXP_WIDTH-1], b[`FXP_WIDTH-2:0]} : b;
  return key_a < key_b;
endfunction

function automatic fxp_word_t expected_result(fxp_cmd_t c);
  case (c.op)
    op_add:  return c.left + c.right;
    op_sub:  return c.left - c.right;
    op_mul:  return expected_product(c.left, c.right, c.is_signed);
    op_div:  return expected_quotient(c.left, c.right, c.is_signed);
    op_lt:   return {{(`FXP_WIDTH-1){1'b0}}, expected_less(c.left, c.right, c.is_signed)};
    op_gt:   return {{(`FXP_WIDTH-1){1'b0}}, expected_less(c.right, c.left, c.is_signed)};
    default: return '0;
  endcase
endfunction

`endif

/* sim/fxp_alu_tb.sv */
// Seeded random commands and back-pressure; needs immediate assertions enabled in the simulator.
`timescale 1ns/1ps
`include "fxp_settings.svh"

module fxp_alu_tb;
  import fxp_pkg::*;

  `include "fxp_model.svh"

  localparam int SEED          = 53162;
  localparam int RANDOM_CMDS   = 400;
  localparam int DIRECTED_CMDS = 6;
  localparam int TOTAL_CMDS    = RANDOM_CMDS + DIRECTED_CMDS;
  localparam int STALL_MAX     = 8;
  localparam int TIMEOUT_NS    = TOTAL_CMDS * (50 + STALL_MAX + 3 + 4) * 10 * 2;

  logic      clk;
  logic      reset;
  logic      cmd_valid;
  fxp_cmd_t  cmd;
  logic      rsp_ready;
  logic      cmd_ready;
  logic      rsp_valid;
  fxp_word_t rsp_data;

  fxp_word_t expected_q[$];
  fxp_word_t expected;
  fxp_word_t held_data;
  logic      rsp_held;
  logic      outstanding;
  int        stall_left;
  int        sent;
  int        received;
  int        data_errors;
  int        protocol_errors;

  fxp_alu_top dut_i (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .rsp_ready (rsp_ready),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data)
  );

  always #5 clk = ~clk;

  function automatic fxp_word_t corner_operand();
    case (3'($urandom_range(5, 0)))
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'h0000_0001;
      3'd2:    return 32'h8000_0000;
      3'd3:    return 32'hFFFF_FFFF;
      3'd4:    return 32'h0001_0000;  // One in Q16.16.
      default: return 32'h7FFF_FFFF;
    endcase
  endfunction

  function automatic fxp_cmd_t make_command(fxp_op_t op, logic sgn, fxp_word_t l, fxp_word_t r);
    fxp_cmd_t c;
    c.op        = op;
    c.is_signed = sgn;
    c.left      = l;
    c.right     = r;
    return c;
  endfunction

  function automatic fxp_cmd_t random_command();
    logic use_corner;
    use_corner = ($urandom_range(7, 0) == 0);
    return make_command(fxp_op_t'(3'($urandom_range(5, 0))), 1'($urandom_range(1, 0)),
                        use_corner ? corner_operand() : fxp_word_t'($urandom),
                        use_corner ? corner_operand() : fxp_word_t'($urandom));
  endfunction

  // Holds cmd until the transfer edge, then drops cmd_valid on the next falling edge.
  task automatic send_command(input fxp_cmd_t c);
    repeat ($urandom_range(3, 0)) @(negedge clk);
    cmd       = c;
    cmd_valid = 1'b1;
    @(posedge clk);
    while (!cmd_ready) @(posedge clk);
    @(negedge clk);
    cmd_valid = 1'b0;
    cmd       = '0;
  endtask

  // Random back-pressure on the response port.
  initial begin
    rsp_ready  = 1'b1;
    stall_left = 0;
    forever begin
      @(negedge clk);
      if (stall_left > 0) begin
        stall_left--;
        rsp_ready = 1'b0;
      end else if ($urandom_range(3, 0) == 0) begin
        stall_left = $urandom_range(STALL_MAX, 0);
        rsp_ready  = (stall_left == 0);
        if (stall_left > 0) stall_left--;
      end else begin
        rsp_ready = 1'b1;
      end
    end
  end

  // Handshakes are sampled at the rising edge, before the DUT registers update.
  always @(posedge clk) begin
    if (!reset) begin
      if (outstanding) begin
        assert (!cmd_ready) else begin
          protocol_errors++;
          $display("cmd_ready went high while a response was still pending");
        end
      end
      if (rsp_held) begin
        assert (rsp_valid) else begin
          protocol_errors++;
          $display("rsp_valid dropped before the response was accepted");
        end
        assert (!rsp_valid || rsp_data == held_data) else begin
          data_errors++;
          $display("[ERROR] rsp_data held 0x%08h changed to 0x%08h", held_data, rsp_data);
        end
      end
      rsp_held  = rsp_valid && !rsp_ready;
      held_data = rsp_data;
      if (cmd_valid && cmd_ready) begin
        expected_q.push_back(expected_result(cmd));  // Model result taken at transfer.
        outstanding = 1'b1;
        sent++;
      end
      if (rsp_valid && rsp_ready) begin
        outstanding = 1'b0;
        assert (expected_q.size() > 0) else begin
          protocol_errors++;
          $display("A response arrived with no command outstanding");
        end
        if (expected_q.size() > 0) begin
          expected = expected_q.pop_front();
          received++;
          assert (rsp_data == expected) else begin
            data_errors++;
            $display("[ERROR] rsp_data expected 0x%08h actual 0x%08h", expected, rsp_data);
          end
        end
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Run timed out with %0d of %0d responses received", received, TOTAL_CMDS);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    clk = 1'b0;
    reset = 1'b1;
    cmd_valid = 1'b0;
    cmd = '0;
    rsp_held = 1'b0;
    outstanding = 1'b0;
    sent = 0;
    received = 0;
    data_errors = 0;
    protocol_errors = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    assert (!rsp_valid && cmd_ready) else begin
      protocol_errors++;
      $display("After reset rsp_valid was not low or cmd_ready was not high");
    end

    // Sign boundary compares and divide by zero first.
    send_command(make_command(op_lt, 1'b1, 32'h8000_0000, 32'h7FFF_FFFF));
    send_command(make_command(op_lt, 1'b0, 32'h8000_0000, 32'h7FFF_FFFF));
    send_command(make_command(op_gt, 1'b1, 32'h8000_0000, 32'h7FFF_FFFF));
    send_command(make_command(op_gt, 1'b0, 32'h8000_0000, 32'h7FFF_FFFF));
    send_command(make_command(op_div, 1'b1, 32'hFFFE_0000, 32'h0000_0000));
    send_command(make_command(op_div, 1'b0, 32'h0005_0000, 32'h0000_0000));
    for (int i = 0; i < RANDOM_CMDS; i++) begin
      send_command(random_command());
    end

    wait (received == TOTAL_CMDS);
    repeat (20) @(negedge clk);  // Gives a stray extra response time to show up.
    assert (!rsp_valid && cmd_ready) else begin
      protocol_errors++;
      $display("The DUT was not idle after the last expected response");
    end

    $display("Summary: %0d commands, %0d data errors, %0d protocol errors",
             sent, data_errors, protocol_errors);
    if (data_errors == 0 && protocol_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* hw/fxp_alu_top.sv */
// One command outstanding at a time; cmd_ready is low from acceptance until the response transfers.
`timescale 1ns/1ps

module fxp_alu_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               cmd_valid,
  input  fxp_pkg::fxp_cmd_t  cmd,
  input  logic               rsp_ready,
  output logic               cmd_ready,
  output logic               rsp_valid,
  output fxp_pkg::fxp_word_t rsp_data
);
  import fxp_pkg::*;

  fxp_state_t state;
  logic       cmd_fire;
  logic       mul_start;
  logic       div_start;
  logic       long_op;
  logic       mul_valid;
  logic       div_done;
  fxp_word_t  fast_result;
  fxp_word_t  mul_product;
  fxp_word_t  div_quotient;

  assign cmd_ready = (state == st_idle);
  assign rsp_valid = (state == st_resp);
  assign cmd_fire  = cmd_valid && cmd_ready;

  // Long operations start in the acceptance cycle itself.
  assign mul_start = cmd_fire && (cmd.op == op_mul);
  assign div_start = cmd_fire && (cmd.op == op_div);
  assign long_op   = mul_start || div_start;

  fxp_addsub_cmp addsub_cmp_i (
    .cmd    (cmd),
    .result (fast_result)
  );

  fxp_mult_pipe mult_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (mul_start),
    .is_signed (cmd.is_signed),
    .left      (cmd.left),
    .right     (cmd.right),
    .out_valid (mul_valid),
    .product   (mul_product)
  );

  fxp_sdiv sdiv_i (
    .clk       (clk),
    .reset     (reset),
    .start     (div_start),
    .is_signed (cmd.is_signed),
    .left      (cmd.left),
    .right     (cmd.right),
    .done      (div_done),
    .quotient  (div_quotient)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (cmd_fire) begin
            state <= long_op ? st_busy : st_resp;
          end
        end
        st_busy: begin
          if (mul_valid || div_done) begin
            state <= st_resp;
          end
        end
        st_resp: begin
          if (rsp_ready) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Held through st_resp so the data stays stable under back-pressure.
  always_ff @(posedge clk) begin
    if (cmd_fire && !long_op) begin
      rsp_data <= fast_result;
    end else if (state == st_busy && mul_valid) begin
      rsp_data <= mul_product;
    end else if (state == st_busy && div_done) begin
      rsp_data <= div_quotient;
    end
  end

endmodule

/* hw/fxp_sdiv.sv */
// Signed results truncate toward zero; the operands only need to be valid in the start cycle.
`timescale 1ns/1ps
`include "fxp_settings.svh"

module fxp_sdiv (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               is_signed,
  input  fxp_pkg::fxp_word_t left,
  input  fxp_pkg::fxp_word_t right,
  output logic               done,
  output fxp_pkg::fxp_word_t quotient
);
  import fxp_pkg::*;

  localparam int W = `FXP_WIDTH;

  logic      left_neg;
  logic      right_neg;
  logic      negate_q;
  fxp_word_t left_mag;
  fxp_word_t right_mag;
  fxp_word_t raw_quotient;

  assign left_neg  = is_signed & left[W-1];
  assign right_neg = is_signed & right[W-1];
  assign left_mag  = left_neg ? -left : left;  // The most negative word maps to 2^31.
  assign right_mag = right_neg ? -right : right;

  // The operands are gone after start, so the sign is kept here.
  always_ff @(posedge clk) begin
    if (reset) begin
      negate_q <= 1'b0;
    end else if (start) begin
      negate_q <= left_neg ^ right_neg;
    end
  end

  fxp_div_iter div_i (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .dividend (left_mag),
    .divisor  (right_mag),
    .done     (done),
    .quotient (raw_quotient)
  );

  assign quotient = negate_q ? -raw_quotient : raw_quotient;

endmodule

/* hw/fxp_div_iter.sv */
// Unsigned operands only; a start while running restarts the division and a zero divisor yields all ones.
`timescale 1ns/1ps
`include "fxp_settings.svh"

module fxp_div_iter (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  fxp_pkg::fxp_word_t dividend,
  input  fxp_pkg::fxp_word_t divisor,
  output logic               done,
  output fxp_pkg::fxp_word_t quotient
);
  import fxp_pkg::*;

  localparam int W = `FXP_WIDTH;
  localparam int ITERS = `FXP_DIV_ITERATIONS;
  localparam int CW = $clog2(ITERS);
  localparam logic [CW-1:0] LAST = CW'(ITERS - 1);

  fxp_word_t      divisor_q;
  logic [ITERS-1:0] shift_q;
  logic [W-1:0]   acc_q;
  logic [W:0]     acc_shift;
  logic [W-1:0]   acc_next;
  logic           quo_bit;
  logic [CW-1:0]  idx_q;
  logic           running;

  // Next numerator bit enters the partial remainder.
  assign acc_shift = {acc_q, shift_q[ITERS-1]};
  assign quo_bit   = (acc_shift >= {1'b0, divisor_q});
  assign acc_next  = quo_bit ? W'(acc_shift - {1'b0, divisor_q}) : acc_shift[W-1:0];

  // After the last shift the low word holds the quotient.
  assign quotient = shift_q[W-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      done    <= 1'b0;
      idx_q   <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        running <= 1'b1;
        idx_q   <= '0;
      end else if (running) begin
        idx_q <= idx_q + 1'b1;
        if (idx_q == LAST) begin
          running <= 1'b0;
          done    <= 1'b1;  // High for one cycle while the quotient is final.
        end
      end
    end
  end

  // Numerator bits leave at the top while quotient bits enter at the bottom.
  always_ff @(posedge clk) begin
    if (start) begin
      shift_q   <= {dividend, {(ITERS - W){1'b0}}};
      acc_q     <= '0;
      divisor_q <= divisor;
    end else if (running) begin
      shift_q <= {shift_q[ITERS-2:0], quo_bit};
      acc_q   <= acc_next;
    end
  end

endmodule

/* hw/fxp_mult_pipe.sv */
// Three register stages with one new input per cycle; the result truncates toward minus infinity.
`timescale 1ns/1ps
`include "fxp_settings.svh"

module fxp_mult_pipe (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  logic               is_signed,
  input  fxp_pkg::fxp_word_t left,
  input  fxp_pkg::fxp_word_t right,
  output logic               out_valid,
  output fxp_pkg::fxp_word_t product
);
  import fxp_pkg::*;

  localparam int W = `FXP_WIDTH;
  localparam int STAGES = `FXP_MULT_STAGES;
  localparam int LSB = `FXP_FRAC_WIDTH;
  localparam int MSB = 2 * `FXP_WIDTH - `FXP_INT_WIDTH - 1;

  fxp_word_t        left_q;
  fxp_word_t        right_q;
  logic             signed_q;
  logic [2*W-1:0]   left_ext;
  logic [2*W-1:0]   right_ext;
  logic [2*W-1:0]   full_q;
  logic [STAGES-1:0] valid_q;

  // Unsigned operands are zero filled.
  assign left_ext  = {{W{signed_q & left_q[W-1]}}, left_q};
  assign right_ext = {{W{signed_q & right_q[W-1]}}, right_q};

  always_ff @(posedge clk) begin
    if (in_valid) begin
      left_q   <= left;
      right_q  <= right;
      signed_q <= is_signed;
    end
    full_q  <= left_ext * right_ext;  // Low 2W bits are right for both signednesses.
    product <= full_q[MSB:LSB];
  end

  // One valid bit per stage.
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[STAGES-2:0], in_valid};
    end
  end

  assign out_valid = valid_q[STAGES-1];

endmodule

/* hw/fxp_addsub_cmp.sv */
// Purely combinational; add and subtract wrap modulo 2^32 and multiply or divide opcodes return zero here.
`timescale 1ns/1ps

module fxp_addsub_cmp (
  input  fxp_pkg::fxp_cmd_t  cmd,
  output fxp_pkg::fxp_word_t result
);
  import fxp_pkg::*;

  logic less;
  logic greater;

  // Signedness only matters for the compares.
  assign less = cmd.is_signed ? ($signed(cmd.left) < $signed(cmd.right))
                              : (cmd.left < cmd.right);
  assign greater = cmd.is_signed ? ($signed(cmd.left) > $signed(cmd.right))
                                 : (cmd.left > cmd.right);

  always_comb begin
    case (cmd.op)
      op_add: begin
        result = cmd.left + cmd.right;
      end
      op_sub: begin
        result = cmd.left - cmd.right;
      end
      op_lt: begin
        result = fxp_word_t'(less);  // Flag in bit 0.
      end
      op_gt: begin
        result = fxp_word_t'(greater);
      end
      default: begin
        result = '0;  // Multiply and divide results come from the other units.
      end
    endcase
  end

endmodule

/* hw/fxp_pkg.sv */
// Command and word types for the fixed-point unit; the opcode encoding is fixed at three bits.
`include "fxp_settings.svh"

package fxp_pkg;

  // One data word, used for operands and results.
  typedef logic [`FXP_WIDTH-1:0] fxp_word_t;

  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_mul = 3'd2,
    op_div = 3'd3,
    op_lt  = 3'd4,
    op_gt  = 3'd5
  } fxp_op_t;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_busy = 2'd1,  // Waiting on the multiplier or the divider.
    st_resp = 2'd2
  } fxp_state_t;

  // One command as seen on the command port.
  typedef struct packed {
    fxp_op_t   op;
    logic      is_signed;
    fxp_word_t left;
    fxp_word_t right;
  } fxp_cmd_t;

endpackage

/* hw/fxp_settings.svh */
// Q16.16 only; FXP_INT_WIDTH plus FXP_FRAC_WIDTH must equal FXP_WIDTH, with three multiply stages.
`ifndef FXP_SETTINGS_SVH
`define FXP_SETTINGS_SVH

// Word width of every operand and result.
`define FXP_WIDTH 32

// Fixed-point split of the word.
`define FXP_FRAC_WIDTH 16
`define FXP_INT_WIDTH 16

// Cycles from multiplier input to output.
`define FXP_MULT_STAGES 3

// One quotient bit per cycle over the numerator scaled by the fraction.
`define FXP_DIV_ITERATIONS (`FXP_WIDTH + `FXP_FRAC_WIDTH)

`endif
